/* Bender.yml */
package:
  name: fetch_front

sources:
  - design/fetch_cfg_pkg.sv
  - design/fetch_types_pkg.sv
  - design/stage_latch.sv
  - design/btb_predictor.sv
  - design/pc_gen.sv
  - design/fetch_front.sv
  - target: test
    files:
      - verif/fetch_checker.sv
      - verif/fetch_front_tb.sv

/* design/btb_predictor.sv */
`timescale 1ns/1ps

module btb_predictor (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic [fetch_cfg_pkg::XLEN-1:0] lookup_pc_i,
  output fetch_types_pkg::predict_t      predict_o,
  input  fetch_types_pkg::branch_res_t   resolve_i
);

  // direct mapped table
  fetch_types_pkg::btb_entry_t btb_q [fetch_cfg_pkg::BTB_DEPTH];

  // read side
  logic [fetch_cfg_pkg::BTB_IDX_W-1:0] rd_idx;
  logic [fetch_cfg_pkg::BTB_TAG_W-1:0] rd_tag;
  fetch_types_pkg::btb_entry_t         rd_entry;
  logic                                rd_hit;

  // write side, driven by the exec resolution
  logic [fetch_cfg_pkg::BTB_IDX_W-1:0] wr_idx;
  logic [fetch_cfg_pkg::BTB_TAG_W-1:0] wr_tag;
  fetch_types_pkg::btb_entry_t         wr_entry_old;
  logic                                wr_hit;
  logic                                do_write;
  logic                                do_clear;

  // lookup path
  assign rd_idx = lookup_pc_i[fetch_cfg_pkg::BTB_IDX_LSB +: fetch_cfg_pkg::BTB_IDX_W];
  assign rd_tag = lookup_pc_i[fetch_cfg_pkg::XLEN-1 -: fetch_cfg_pkg::BTB_TAG_W];

  assign rd_entry = btb_q[rd_idx];
  assign rd_hit   = rd_entry.valid && (rd_entry.tag == rd_tag);

  // prediction is same-cycle, no flop in between
  assign predict_o.hit    = rd_hit;
  assign predict_o.target = rd_entry.target;

  // update path
  assign wr_idx = resolve_i.src_pc[fetch_cfg_pkg::BTB_IDX_LSB +: fetch_cfg_pkg::BTB_IDX_W];
  assign wr_tag = resolve_i.src_pc[fetch_cfg_pkg::XLEN-1 -: fetch_cfg_pkg::BTB_TAG_W];

  assign wr_entry_old = btb_q[wr_idx];
  assign wr_hit       = wr_entry_old.valid && (wr_entry_old.tag == wr_tag);

  // taken branches allocate or refresh
  assign do_write = resolve_i.valid && resolve_i.taken;

  // not taken only evicts its own line, an alias stays put
  assign do_clear = resolve_i.valid && !resolve_i.taken && wr_hit;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < fetch_cfg_pkg::BTB_DEPTH; i++) begin
        btb_q[i] <= '0;
      end
    end else if (do_write) begin
      btb_q[wr_idx].valid  <= 1'b1;
      btb_q[wr_idx].tag    <= wr_tag;
      btb_q[wr_idx].target <= resolve_i.target;
    end else if (do_clear) begin
      btb_q[wr_idx].valid <= 1'b0;  // tag and target left stale
    end
  end

  // a misaligned target would only come from a bad exec resolution
  a_hit_aligned : assert property (@(posedge clk) disable iff (!rst_n_i)
    predict_o.hit |-> (predict_o.target[1:0] == 2'b00));

endmodule

/* design/fetch_cfg_pkg.sv */
package fetch_cfg_pkg;

  // datapath widths
  localparam int unsigned XLEN     = 32;  // pc and address width
  localparam int unsigned INST_LEN = 32;  // fixed-size instructions, no compressed

  // byte distance between two sequential fetches
  localparam int unsigned PC_STEP = INST_LEN / 8;

  // restart point after reset or flush
  localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h8000_0000;

  // branch target buffer geometry
  localparam int unsigned BTB_DEPTH   = 16;
  localparam int unsigned BTB_IDX_W   = $clog2(BTB_DEPTH);  // 4 bits
  localparam int unsigned BTB_IDX_LSB = 2;  // skip the byte offset inside a word

  // everything above the index is tag
  localparam int unsigned BTB_TAG_W = XLEN - BTB_IDX_W - BTB_IDX_LSB;

endpackage

/* design/fetch_front.sv */
`timescale 1ns/1ps

module fetch_front (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic                           stall_i,
  input  logic                           flush_i,
  input  fetch_types_pkg::redirect_t     trap_i,
  input  fetch_types_pkg::branch_res_t   branch_i,
  output fetch_types_pkg::icache_req_t   icache_req_o,
  output logic [fetch_cfg_pkg::XLEN-1:0] pc_o,
  output fetch_types_pkg::if_payload_t   if_o,
  output logic                           if_valid_o
);

  fetch_types_pkg::predict_t    predict;     // raw btb lookup
  logic                         pred_taken;  // btb steered this fetch
  fetch_types_pkg::if_payload_t if_d;
  fetch_types_pkg::predict_t    pred_d;
  fetch_types_pkg::predict_t    pred_q;
  logic                         pred_valid;

  pc_gen u_pc_gen (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .trap_i       (trap_i),
    .branch_i     (branch_i),
    .predict_i    (predict),
    .icache_req_o (icache_req_o),
    .pc_o         (pc_o),
    .pred_taken_o (pred_taken)
  );

  btb_predictor u_btb (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (pc_o),
    .predict_o   (predict),
    .resolve_i   (branch_i)
  );

  assign if_d.pc         = pc_o;
  assign if_d.pred_taken = pred_taken;

  stage_latch #(
    .payload_t (fetch_types_pkg::if_payload_t)
  ) u_if_latch (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .valid_i (icache_req_o.req),
    .data_i  (if_d),
    .valid_o (if_valid_o),
    .data_o  (if_o)
  );

  // only the prediction that won, so a lost hit does not show up
  assign pred_d.hit    = pred_taken;
  assign pred_d.target = predict.target;

  stage_latch #(
    .payload_t (fetch_types_pkg::predict_t)
  ) u_pred_latch (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .valid_i (icache_req_o.req),
    .data_i  (pred_d),
    .valid_o (pred_valid),
    .data_o  (pred_q)
  );

  // a predicted fetch in IF must be followed by its target in the pc
  a_pred_follow : assert property (@(posedge clk) disable iff (!rst_n_i)
    (if_valid_o && pred_valid) |->
      (if_o.pred_taken == pred_q.hit) && (!pred_q.hit || pc_o == pred_q.target));

endmodule

/* design/fetch_types_pkg.sv */
package fetch_types_pkg;

  // redirect request, used for the trap path from mem
  typedef struct packed {
    logic                           valid;
    logic [fetch_cfg_pkg::XLEN-1:0] target;
    logic [fetch_cfg_pkg::XLEN-1:0] src_pc;
  } redirect_t;

  // branch outcome from exec, trains the btb
  typedef struct packed {
    logic                           valid;
    logic [fetch_cfg_pkg::XLEN-1:0] src_pc;
    logic [fetch_cfg_pkg::XLEN-1:0] target;
    logic                           taken;
  } branch_res_t;

  // btb lookup result
  typedef struct packed {
    logic                           hit;
    logic [fetch_cfg_pkg::XLEN-1:0] target;
  } predict_t;

  // one btb line
  typedef struct packed {
    logic                                valid;
    logic [fetch_cfg_pkg::BTB_TAG_W-1:0] tag;
    logic [fetch_cfg_pkg::XLEN-1:0]      target;
  } btb_entry_t;

  // read request towards the icache
  typedef struct packed {
    logic                           req;
    logic [fetch_cfg_pkg::XLEN-1:0] addr;
  } icache_req_t;

  // what the IF stage receives
  typedef struct packed {
    logic [fetch_cfg_pkg::XLEN-1:0] pc;
    logic                           pred_taken;
  } if_payload_t;

endpackage

/* design/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic                           stall_i,
  input  logic                           flush_i,
  input  fetch_types_pkg::redirect_t     trap_i,
  input  fetch_types_pkg::branch_res_t   branch_i,
  input  fetch_types_pkg::predict_t      predict_i,
  output fetch_types_pkg::icache_req_t   icache_req_o,
  output logic [fetch_cfg_pkg::XLEN-1:0] pc_o,
  output logic                           pred_taken_o
);

  logic [fetch_cfg_pkg::XLEN-1:0] pc_q;
  logic [fetch_cfg_pkg::XLEN-1:0] pc_seq;   // fall-through address
  logic [fetch_cfg_pkg::XLEN-1:0] pc_sel;   // before flush
  logic [fetch_cfg_pkg::XLEN-1:0] pc_next;  // after flush
  logic                           btb_win;
  logic                           pc_wen;
  logic                           req_q;

  assign pc_seq = pc_q + fetch_cfg_pkg::XLEN'(fetch_cfg_pkg::PC_STEP);

  // trap, then resolved branch, then btb, then sequential
  always_comb begin
    btb_win = 1'b0;
    if (trap_i.valid) begin
      pc_sel = trap_i.target;
    end else if (branch_i.valid && branch_i.taken) begin
      pc_sel = branch_i.target;
    end else if (predict_i.hit) begin
      pc_sel  = predict_i.target;
      btb_win = 1'b1;
    end else begin
      pc_sel = pc_seq;
    end
  end

  // flush has the last word
  assign pc_next = flush_i ? fetch_cfg_pkg::PC_RESET_ADDR : pc_sel;

  assign pc_wen = !stall_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= fetch_cfg_pkg::PC_RESET_ADDR;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  // request rises on the first edge out of reset and stays up
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= 1'b1;
    end
  end

  // cache sees the address the pc register will hold next
  assign icache_req_o.req  = req_q;
  assign icache_req_o.addr = stall_i ? pc_q : pc_next;

  assign pc_o = pc_q;

  // prediction that actually steered the fetch
  assign pred_taken_o = btb_win && !flush_i;

  a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n_i)
    pc_q[1:0] == 2'b00);

  // stall freezes the pc for the cycle after it is seen
  a_pc_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i |=> (pc_q == $past(pc_q)));

endmodule

/* design/stage_latch.sv */
`timescale 1ns/1ps

module stage_latch #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     stall_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // valid bit: flush beats stall
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // payload only moves when the pipe advances
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      data_o <= data_i;
    end
  end

  // downstream may sample a held entry over several cycles
  a_hold_on_stall : assert property (@(posedge clk) disable iff (!rst_n_i)
    (valid_o && stall_i) |=> $stable(data_o));

endmodule

/* fetch_front.f */
design/fetch_cfg_pkg.sv
design/fetch_types_pkg.sv
design/stage_latch.sv
design/btb_predictor.sv
design/pc_gen.sv
design/fetch_front.sv
verif/fetch_checker.sv
verif/fetch_front_tb.sv

/* verif/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  fetch_types_pkg::icache_req_t   icache_req_i,
  input  logic [fetch_cfg_pkg::XLEN-1:0] pc_i,
  input  fetch_types_pkg::if_payload_t   if_i,
  input  logic                           if_valid_i,
  input  logic [3:0]                     test_id_i,
  input  fetch_types_pkg::icache_req_t   exp_req_i,
  input  logic [fetch_cfg_pkg::XLEN-1:0] exp_pc_i,
  input  fetch_types_pkg::if_payload_t   exp_if_i,
  input  logic                           exp_if_valid_i,
  input  logic                           trace_done_i,
  output logic                           finished_o,
  output int                             error_count_o
);

  localparam int TRACE_TIMEOUT = 100;  // cycles, reset included

  logic [3:0] cur_id;
  int         test_checks;
  int         test_errors;
  int         tests_run;
  int         tests_passed;

  function automatic string test_label(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_and_sequential";
      4'd2:    return "stall_hold";
      4'd3:    return "redirect_priority";
      4'd4:    return "btb_learning";
      4'd5:    return "flush";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare_word(input string what,
                              input logic [fetch_cfg_pkg::XLEN-1:0] expected,
                              input logic [fetch_cfg_pkg::XLEN-1:0] actual);
    test_checks++;
    if (actual !== expected) begin
      test_errors++;
      error_count_o++;
      $display("Error %s %s: expected %h, actual %h",
               test_label(cur_id), what, expected, actual);
    end
  endtask

  task automatic check_cycle();
    compare_word("icache req", 32'(exp_req_i.req), 32'(icache_req_i.req));
    compare_word("icache addr", exp_req_i.addr, icache_req_i.addr);
    compare_word("pc", exp_pc_i, pc_i);
    compare_word("if valid", 32'(exp_if_valid_i), 32'(if_valid_i));
    if (exp_if_valid_i) begin  // payload is meaningless while invalid
      compare_word("if pc", exp_if_i.pc, if_i.pc);
      compare_word("if pred_taken", 32'(exp_if_i.pred_taken), 32'(if_i.pred_taken));
    end
  endtask

  task automatic close_test();
    if (cur_id != 4'd0) begin
      tests_run++;
      if (test_errors == 0) begin
        tests_passed++;
        $display("test %s: ok, %0d checks", test_label(cur_id), test_checks);
      end else begin
        $display("test %s: %0d of %0d checks wrong", test_label(cur_id),
                 test_errors, test_checks);
      end
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    int   cycles;
    logic done;
    finished_o    = 1'b0;
    error_count_o = 0;
    cur_id        = 4'd0;
    test_checks   = 0;
    test_errors   = 0;
    tests_run     = 0;
    tests_passed  = 0;
    cycles        = 0;
    done          = 1'b0;
    // outputs are settled half a cycle after the edge
    while (!done && cycles < TRACE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (rst_n_i && trace_done_i) begin
        done = 1'b1;
      end else if (rst_n_i) begin  // nothing to compare while in reset
        if (test_id_i != cur_id) begin
          close_test();
          cur_id = test_id_i;
        end
        check_cycle();
      end
    end
    close_test();
    if (!done) begin
      $display("timeout: the trace did not finish within %0d cycles", TRACE_TIMEOUT);
      error_count_o++;
    end
    $display("summary: %0d tests, %0d ok, %0d failed, %0d errors", tests_run,
             tests_passed, tests_run - tests_passed, error_count_o);
    finished_o = 1'b1;
  end

endmodule

/* verif/fetch_front_tb.sv */
`timescale 1ns/1ps

module fetch_front_tb;

  localparam int HALF_PERIOD    = 10;   // 20 ns clock
  localparam int DRIVE_DELAY    = 2;    // inputs move this long after the rising edge
  localparam int RESET_CYCLES   = 5;
  localparam int TRACE_LINES    = 25;
  localparam int LINE_WORDS     = 8;    // hex words per trace line
  localparam int TRACE_WORDS    = TRACE_LINES * LINE_WORDS;
  localparam int FINISH_TIMEOUT = 150;  // cycles to wait for the checker

  logic                           clk;
  logic                           rst_n;
  logic                           stall;
  logic                           flush;
  fetch_types_pkg::redirect_t     trap;
  fetch_types_pkg::branch_res_t   branch;
  fetch_types_pkg::icache_req_t   icache_req;
  logic [fetch_cfg_pkg::XLEN-1:0] pc;
  fetch_types_pkg::if_payload_t   if_data;
  logic                           if_valid;

  // expectations for the line currently applied
  fetch_types_pkg::icache_req_t   exp_req;
  logic [fetch_cfg_pkg::XLEN-1:0] exp_pc;
  fetch_types_pkg::if_payload_t   exp_if;
  logic                           exp_if_valid;
  logic [3:0]                     test_id;
  logic                           trace_done;

  logic                           finished;
  int                             error_count;

  logic [31:0] trace_mem [TRACE_WORDS];

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  fetch_front fetch_front_i (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .stall_i      (stall),
    .flush_i      (flush),
    .trap_i       (trap),
    .branch_i     (branch),
    .icache_req_o (icache_req),
    .pc_o         (pc),
    .if_o         (if_data),
    .if_valid_o   (if_valid)
  );

  fetch_checker u_checker (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .icache_req_i   (icache_req),
    .pc_i           (pc),
    .if_i           (if_data),
    .if_valid_i     (if_valid),
    .test_id_i      (test_id),
    .exp_req_i      (exp_req),
    .exp_pc_i       (exp_pc),
    .exp_if_i       (exp_if),
    .exp_if_valid_i (exp_if_valid),
    .trace_done_i   (trace_done),
    .finished_o     (finished),
    .error_count_o  (error_count)
  );

  task automatic drive_idle();
    stall        = 1'b0;
    flush        = 1'b0;
    trap         = '0;
    branch       = '0;
    exp_req      = '0;
    exp_pc       = '0;
    exp_if       = '0;
    exp_if_valid = 1'b0;
    test_id      = 4'd0;
  endtask

  // unpack one trace line onto the DUT inputs and the checker
  task automatic apply_line(input int n);
    logic [31:0] ctrl;
    logic [31:0] flags;
    int          base;
    base  = n * LINE_WORDS;
    ctrl  = trace_mem[base];
    flags = trace_mem[base + 7];
    test_id       = ctrl[31:28];
    stall         = ctrl[24];
    flush         = ctrl[20];
    trap.valid    = ctrl[16];
    trap.target   = trace_mem[base + 1];
    trap.src_pc   = '0;  // not used by fetch
    branch.valid  = ctrl[12];
    branch.taken  = ctrl[8];
    branch.src_pc = trace_mem[base + 2];
    branch.target = trace_mem[base + 3];
    exp_req.req   = flags[8];
    exp_req.addr  = trace_mem[base + 4];
    exp_pc        = trace_mem[base + 5];
    exp_if.pc     = trace_mem[base + 6];
    exp_if.pred_taken = flags[0];
    exp_if_valid  = flags[4];
  endtask

  initial begin
    rst_n      = 1'b0;
    trace_done = 1'b0;
    drive_idle();
    $readmemh("verif/fetch_trace.txt", trace_mem);
    if ($isunknown(trace_mem[0]) || $isunknown(trace_mem[TRACE_WORDS-1])) begin
      $display("trace file verif/fetch_trace.txt is missing or too short");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      apply_line(0);  // first line rides along with the reset release
      for (int n = 1; n < TRACE_LINES; n++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        apply_line(n);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      drive_idle();
      trace_done = 1'b1;
    end
  end

  initial begin : verdict
    int waited;
    waited = 0;
    while (finished !== 1'b1 && waited < FINISH_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (finished !== 1'b1) begin
      $display("checker did not finish within %0d cycles", FINISH_TIMEOUT);
      $display("TEST RESULT: FAIL");
    end else if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verif/fetch_trace.txt */
// ctrl digits: test id, stall, flush, trap valid, branch valid, branch taken, 0, 0
// then trap target, branch pc, branch target, exp addr, exp pc, exp if pc, exp req/ifv/pred
// test 1 reset and sequential fetch
10000000 00000000 00000000 00000000 80000004 80000000 00000000 00000000
10000000 00000000 00000000 00000000 80000008 80000004 00000000 00000100
10000000 00000000 00000000 00000000 8000000C 80000008 80000004 00000110
10000000 00000000 00000000 00000000 80000010 8000000C 80000008 00000110
// test 2 stall holds pc, addr and if
21000000 00000000 00000000 00000000 80000010 80000010 8000000C 00000110
21000000 00000000 00000000 00000000 80000010 80000010 8000000C 00000110
20000000 00000000 00000000 00000000 80000014 80000010 8000000C 00000110
// test 3 trap over branch, then branch alone
30011100 80000100 80000F00 80000200 80000100 80000014 80000010 00000110
30001100 00000000 80000F04 80000200 80000200 80000100 80000014 00000110
30000000 00000000 00000000 00000000 80000204 80000200 80000100 00000110
// test 4 train 8000020C to 80000200, predict, then untrain
40001100 00000000 8000020C 80000200 80000200 80000204 80000200 00000110
40000000 00000000 00000000 00000000 80000204 80000200 80000204 00000110
40000000 00000000 00000000 00000000 80000208 80000204 80000200 00000110
40000000 00000000 00000000 00000000 8000020C 80000208 80000204 00000110
40000000 00000000 00000000 00000000 80000200 8000020C 80000208 00000110
40001000 00000000 8000020C 00000000 80000204 80000200 8000020C 00000111
40000000 00000000 00000000 00000000 80000208 80000204 80000200 00000110
40000000 00000000 00000000 00000000 8000020C 80000208 80000204 00000110
40000000 00000000 00000000 00000000 80000210 8000020C 80000208 00000110
40000000 00000000 00000000 00000000 80000214 80000210 8000020C 00000110
// test 5 flush, alone and over a trap
50100000 00000000 00000000 00000000 80000000 80000214 80000210 00000110
50000000 00000000 00000000 00000000 80000004 80000000 00000000 00000100
50000000 00000000 00000000 00000000 80000008 80000004 80000000 00000110
50110000 80000100 00000000 00000000 80000000 80000008 80000004 00000110
50000000 00000000 00000000 00000000 80000004 80000000 00000000 00000100
